/* Bender.yml */
package:
  name: rv32i_issue

sources:
  - verilog/rv32i_issue_pkg.sv
  - verilog/issue_cfg_pkg.sv
  - verilog/issue_fifo.sv
  - verilog/issue_ctrl.sv
  - verilog/res_station_bank.sv
  - verilog/rob_alloc.sv
  - verilog/ldst_queue.sv
  - verilog/issue_top.sv
  - target: test
    files:
      - bench/tb_issue.sv

/* bench/tb_issue.sv */
`timescale 1ns/1ps

module tb_issue;
    import rv32i_issue_pkg::*;
    import issue_cfg_pkg::*;

    // run limit is the sum of per-test budgets plus 20 percent
    localparam int TEST_CYCLES = 40 + 80 + 140 + 140 + 160;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 12 / 10;

    logic       clk;
    logic       rst_i;
    logic       ld_iq_i;
    ctl_word_t  ctl_word_i;
    logic       ack_o;
    logic       exec_done_i;
    rs_id_t     exec_rs_i;
    logic       retire_i;
    logic       mem_done_i;
    logic       issue_valid_o;
    issue_rec_t issue_o;
    logic       rob_full_o;
    logic       lsq_full_o;

    // expected records in program order
    issue_rec_t sb [$];

    // reference model of the resources
    logic rs_busy [NUM_RS];
    int   next_tag;
    int   rob_cnt;
    int   lsq_cnt;

    int seed;
    int mismatch_cnt;
    int other_cnt;
    int cycle_cnt;

    issue_top i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .ld_iq_i       (ld_iq_i),
        .ctl_word_i    (ctl_word_i),
        .ack_o         (ack_o),
        .exec_done_i   (exec_done_i),
        .exec_rs_i     (exec_rs_i),
        .retire_i      (retire_i),
        .mem_done_i    (mem_done_i),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o),
        .rob_full_o    (rob_full_o),
        .lsq_full_o    (lsq_full_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    // random register and immediate fields
    function automatic ctl_word_t make_word(input op_class_e op);
        ctl_word_t w;
        w.op       = op;
        w.dest_reg = reg_idx_t'($random(seed));
        w.src1_reg = reg_idx_t'($random(seed));
        w.src2_reg = reg_idx_t'($random(seed));
        w.imm      = imm_t'($random(seed));
        w.funct    = funct_t'($random(seed));
        return w;
    endfunction

    // monitor samples mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst_i && issue_valid_o) begin
            if (sb.size() == 0) begin
                $display("unexpected issue at %0t: record %h", $time, issue_o);
                other_cnt++;
            end else begin
                check_value("issue_o", sb.pop_front(), issue_o);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic reset_dut();
        @(posedge clk);
        rst_i <= 1'b1;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        sb.delete();
        for (int i = 0; i < NUM_RS; i++) begin
            rs_busy[i] = 1'b0;
        end
        next_tag = 0;
        rob_cnt  = 0;
        lsq_cnt  = 0;
        // everything empty after reset
        @(negedge clk);
        check_value("issue_valid_o", 1'b0, issue_valid_o);
        check_value("rob_full_o", 1'b0, rob_full_o);
        check_value("lsq_full_o", 1'b0, lsq_full_o);
        check_value("ack_o", 1'b0, ack_o);
    endtask

    // hold the request until ack and return at the accepting edge
    task automatic enqueue_word(input ctl_word_t w);
        int waited;
        waited = 0;
        @(posedge clk);
        ld_iq_i    <= 1'b1;
        ctl_word_i <= w;
        @(negedge clk);
        while (!ack_o && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!ack_o) begin
            $display("request not acknowledged by %0t", $time);
            other_cnt++;
        end
        @(posedge clk);
        ld_iq_i <= 1'b0;
    endtask

    // expected record from the issue rules
    task automatic predict(input ctl_word_t w, output rs_id_t rs);
        issue_rec_t rec;
        int         pick;
        pick = -1;
        if (w.op == LD || w.op == ST) begin
            pick = LDST_RS_ID;
        end else begin
            // lowest free alu station wins
            for (int i = NUM_ALU_RS - 1; i >= 0; i--) begin
                if (!rs_busy[i]) begin
                    pick = i;
                end
            end
        end
        if (pick < 0) begin
            $display("no free station for the predicted issue at %0t", $time);
            other_cnt++;
            pick = 0;
        end
        rec.word = w;
        rec.tag  = rob_tag_t'(next_tag);
        rec.rs   = rs_id_t'(pick);
        sb.push_back(rec);
        rs_busy[pick] = 1'b1;
        next_tag = (next_tag + 1) % ROB_DEPTH;
        rob_cnt++;
        if (w.op == LD || w.op == ST) begin
            lsq_cnt++;
        end
        rs = rec.rs;
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (sb.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (sb.size() != 0) begin
            $display("issue missing: %0d expected records not issued by %0t", sb.size(), $time);
            other_cnt++;
            sb.delete();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // one-cycle completion strobes
    task automatic finish_exec(input int rs);
        rs_busy[rs] = 1'b0;
        @(posedge clk);
        exec_done_i <= 1'b1;
        exec_rs_i   <= rs_id_t'(rs);
        @(posedge clk);
        exec_done_i <= 1'b0;
    endtask

    task automatic retire_one();
        rob_cnt--;
        @(posedge clk);
        retire_i <= 1'b1;
        @(posedge clk);
        retire_i <= 1'b0;
    endtask

    task automatic complete_mem();
        lsq_cnt--;
        @(posedge clk);
        mem_done_i <= 1'b1;
        @(posedge clk);
        mem_done_i <= 1'b0;
    endtask

    // one edge to enqueue, one edge to dispatch
    task automatic single_alu_latency();
        ctl_word_t w;
        rs_id_t    rs;
        reset_dut();
        w = make_word(ALU);
        predict(w, rs);
        enqueue_word(w);
        // dispatch edge still ahead
        @(negedge clk);
        check_value("issue_valid_o", 1'b0, issue_valid_o);
        @(negedge clk);
        check_value("issue_valid_o", 1'b1, issue_valid_o);
        @(negedge clk);
        check_value("issue_valid_o", 1'b0, issue_valid_o);
        wait_drain(10);
    endtask

    task automatic station_fill_order();
        ctl_word_t w [5];
        rs_id_t    rs;
        reset_dut();
        for (int i = 0; i < 5; i++) begin
            w[i] = make_word(ALU);
        end
        for (int i = 0; i < 4; i++) begin
            predict(w[i], rs);
        end
        for (int i = 0; i < 5; i++) begin
            enqueue_word(w[i]);
        end
        wait_drain(20);
        // fifth word has no station yet
        idle_cycles(5);
        finish_exec(2);
        predict(w[4], rs);
        wait_drain(20);
    endtask

    task automatic ldst_routing();
        ctl_word_t m [5];
        ctl_word_t a;
        rs_id_t    rs;
        reset_dut();
        m[0] = make_word(LD);
        m[1] = make_word(LD);
        m[2] = make_word(ST);
        m[3] = make_word(LD);
        m[4] = make_word(LD);
        a    = make_word(ALU);
        predict(m[0], rs);
        enqueue_word(m[0]);
        wait_drain(20);
        // each memory word waits for the memory station
        for (int i = 1; i < 4; i++) begin
            enqueue_word(m[i]);
            idle_cycles(4);
            finish_exec(LDST_RS_ID);
            predict(m[i], rs);
            wait_drain(20);
        end
        @(negedge clk);
        check_value("lsq_full_o", lsq_cnt == LSQ_DEPTH, lsq_full_o);
        // alu word stays behind the blocked load
        enqueue_word(m[4]);
        enqueue_word(a);
        finish_exec(LDST_RS_ID);
        idle_cycles(4);
        complete_mem();
        predict(m[4], rs);
        predict(a, rs);
        wait_drain(20);
        @(negedge clk);
        check_value("lsq_full_o", lsq_cnt == LSQ_DEPTH, lsq_full_o);
    endtask

    task automatic rob_full_stall();
        ctl_word_t w;
        rs_id_t    rs;
        reset_dut();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            w = make_word(ALU);
            predict(w, rs);
            enqueue_word(w);
            wait_drain(20);
            finish_exec(rs);
        end
        @(negedge clk);
        check_value("rob_full_o", rob_cnt == ROB_DEPTH, rob_full_o);
        // each retire lets one word through and tags wrap to 0
        for (int i = 0; i < 2; i++) begin
            w = make_word(ALU);
            enqueue_word(w);
            idle_cycles(4);
            retire_one();
            predict(w, rs);
            wait_drain(20);
            @(negedge clk);
            check_value("rob_full_o", rob_cnt == ROB_DEPTH, rob_full_o);
        end
    endtask

    task automatic queue_full_drain();
        ctl_word_t q [IQ_DEPTH];
        ctl_word_t w;
        ctl_word_t extra;
        rs_id_t    rs;
        reset_dut();
        // occupy every alu station
        for (int i = 0; i < NUM_ALU_RS; i++) begin
            w = make_word(ALU);
            predict(w, rs);
            enqueue_word(w);
        end
        wait_drain(20);
        for (int i = 0; i < IQ_DEPTH; i++) begin
            q[i] = make_word(i % 2 == 0 ? MUL : BR);
            enqueue_word(q[i]);
        end
        // full queue refuses the request
        extra = make_word(ALU);
        @(posedge clk);
        ld_iq_i    <= 1'b1;
        ctl_word_i <= extra;
        repeat (3) begin
            @(negedge clk);
            check_value("ack_o", 1'b0, ack_o);
        end
        @(posedge clk);
        ld_iq_i <= 1'b0;
        // stations freed one by one so words leave in order
        for (int k = 0; k < IQ_DEPTH; k++) begin
            retire_one();
            finish_exec(k % NUM_ALU_RS);
            predict(q[k], rs);
            wait_drain(20);
        end
        // retried request now fits
        retire_one();
        finish_exec(0);
        predict(extra, rs);
        enqueue_word(extra);
        wait_drain(20);
    endtask

    initial begin
        rst_i        = 1'b1;
        ld_iq_i      = 1'b0;
        ctl_word_i   = '0;
        exec_done_i  = 1'b0;
        exec_rs_i    = '0;
        retire_i     = 1'b0;
        mem_done_i   = 1'b0;
        seed         = 57622;
        mismatch_cnt = 0;
        other_cnt    = 0;
        cycle_cnt    = 0;

        single_alu_latency();
        station_fill_order();
        ldst_routing();
        rob_full_stall();
        queue_full_drain();
        idle_cycles(4);

        $display("error count: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/rv32i_issue_pkg.sv
verilog/issue_cfg_pkg.sv
verilog/issue_fifo.sv
verilog/issue_ctrl.sv
verilog/res_station_bank.sv
verilog/rob_alloc.sv
verilog/ldst_queue.sv
verilog/issue_top.sv
bench/tb_issue.sv

/* verilog/issue_cfg_pkg.sv */
package issue_cfg_pkg;

    // sizing of the issue structures
    localparam int IQ_DEPTH   = 8;
    localparam int ROB_DEPTH  = 8;
    localparam int LSQ_DEPTH  = 4;
    localparam int NUM_ALU_RS = 4;
    // memory station sits right after the alu stations
    localparam int LDST_RS_ID = NUM_ALU_RS;
    localparam int NUM_RS     = NUM_ALU_RS + 1;

    // pointers and occupancy counters
    typedef logic [$clog2(IQ_DEPTH)-1:0]    iq_ptr_t;
    typedef logic [$clog2(IQ_DEPTH+1)-1:0]  iq_cnt_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_tag_t;
    typedef logic [$clog2(ROB_DEPTH+1)-1:0] rob_cnt_t;
    typedef logic [$clog2(LSQ_DEPTH+1)-1:0] lsq_cnt_t;

    // station index and one-hot station load vector
    typedef logic [$clog2(NUM_RS)-1:0] rs_id_t;
    typedef logic [NUM_RS-1:0]         rs_sel_t;

    // record reported for every dispatch
    typedef struct packed {
        rv32i_issue_pkg::ctl_word_t word;
        rob_tag_t                   tag;
        rs_id_t                     rs;
    } issue_rec_t;

endpackage

/* verilog/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
    // request side from the IR stage
    input  logic                               ld_iq_i,
    output logic                               ack_o,
    // queue status and head
    input  logic                               fifo_ready_i,
    input  logic                               fifo_valid_i,
    input  rv32i_issue_pkg::ctl_word_t         head_i,
    output logic                               enqueue_o,
    output logic                               dequeue_o,
    // resource status
    input  logic [issue_cfg_pkg::NUM_ALU_RS-1:0] alu_rs_empty_i,
    input  logic                               ldst_rs_empty_i,
    input  logic                               rob_full_i,
    input  logic                               lsq_full_i,
    // allocation strobes
    output issue_cfg_pkg::rs_sel_t             rs_load_o,
    output logic                               rob_load_o,
    output logic                               lsq_load_o
);
    import rv32i_issue_pkg::*;
    import issue_cfg_pkg::*;

    logic                  is_mem;
    logic                  any_alu_free;
    logic [NUM_ALU_RS-1:0] alu_pick;

    // enqueue side
    // acknowledge in the same cycle while the queue has room
    assign ack_o     = ld_iq_i && fifo_ready_i;
    assign enqueue_o = ack_o;

    // head class decides the station kind
    assign is_mem = (head_i.op == LD) || (head_i.op == ST);

    // lowest free alu station
    // isolate the lowest set bit of the empty mask
    assign alu_pick     = alu_rs_empty_i & (~alu_rs_empty_i + 1'b1);
    assign any_alu_free = |alu_rs_empty_i;

    // dequeue side
    always_comb begin
        rs_load_o  = '0;
        dequeue_o  = 1'b0;
        lsq_load_o = 1'b0;
        // every dispatch needs a rob slot
        if (fifo_valid_i && !rob_full_i) begin
            if (is_mem) begin
                // memory ops also need an lsq entry
                if (ldst_rs_empty_i && !lsq_full_i) begin
                    rs_load_o[LDST_RS_ID] = 1'b1;
                    dequeue_o             = 1'b1;
                    lsq_load_o            = 1'b1;
                end
            end else if (any_alu_free) begin
                rs_load_o[NUM_ALU_RS-1:0] = alu_pick;
                dequeue_o                 = 1'b1;
            end
        end
    end

    // tag allocation follows the dequeue
    assign rob_load_o = dequeue_o;

endmodule

/* verilog/issue_fifo.sv */
`timescale 1ns/1ps

module issue_fifo (
    input  logic                       clk,
    input  logic                       rst_i,
    input  rv32i_issue_pkg::ctl_word_t data_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic                       valid_o,
    output rv32i_issue_pkg::ctl_word_t data_o,
    input  logic                       yumi_i
);
    import rv32i_issue_pkg::*;
    import issue_cfg_pkg::*;

    // circular storage of control words
    ctl_word_t mem [IQ_DEPTH];
    iq_ptr_t   wr_ptr_q;
    iq_ptr_t   rd_ptr_q;
    iq_cnt_t   count_q;
    logic      do_push;
    logic      do_pop;

    // room left or head present
    assign ready_o = (count_q < IQ_DEPTH);
    assign valid_o = (count_q != '0);
    // head word straight from storage
    assign data_o  = mem[rd_ptr_q];

    // pop only a valid head
    assign do_pop  = yumi_i && valid_o;
    // a pop in the same edge frees the slot for a push when full
    assign do_push = valid_i && (ready_o || do_pop);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == iq_ptr_t'(IQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == iq_ptr_t'(IQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // occupancy holds when both happen
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* verilog/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
    input  logic                       clk,
    input  logic                       rst_i,
    // IR stage handshake
    input  logic                       ld_iq_i,
    input  rv32i_issue_pkg::ctl_word_t ctl_word_i,
    output logic                       ack_o,
    // completion strobes
    input  logic                       exec_done_i,
    input  issue_cfg_pkg::rs_id_t      exec_rs_i,
    input  logic                       retire_i,
    input  logic                       mem_done_i,
    // issued record
    output logic                       issue_valid_o,
    output issue_cfg_pkg::issue_rec_t  issue_o,
    output logic                       rob_full_o,
    output logic                       lsq_full_o
);
    import rv32i_issue_pkg::*;
    import issue_cfg_pkg::*;

    logic                  fifo_ready;
    logic                  fifo_valid;
    logic                  enqueue;
    logic                  dequeue;
    ctl_word_t             head_word;
    logic [NUM_ALU_RS-1:0] alu_empty;
    logic                  ldst_empty;
    rs_sel_t               rs_load;
    logic                  rob_load;
    logic                  lsq_load;
    rob_tag_t              tail_tag;
    rs_id_t                disp_rs;
    issue_rec_t            disp_rec;
    logic                  issue_valid_q;
    issue_rec_t            issue_q;

    // in-order issue queue
    issue_fifo i_fifo (
        .clk     (clk),
        .rst_i   (rst_i),
        .data_i  (ctl_word_i),
        .valid_i (enqueue),
        .ready_o (fifo_ready),
        .valid_o (fifo_valid),
        .data_o  (head_word),
        .yumi_i  (dequeue)
    );

    // handshake and dispatch decision
    issue_ctrl i_ctrl (
        .ld_iq_i         (ld_iq_i),
        .ack_o           (ack_o),
        .fifo_ready_i    (fifo_ready),
        .fifo_valid_i    (fifo_valid),
        .head_i          (head_word),
        .enqueue_o       (enqueue),
        .dequeue_o       (dequeue),
        .alu_rs_empty_i  (alu_empty),
        .ldst_rs_empty_i (ldst_empty),
        .rob_full_i      (rob_full_o),
        .lsq_full_i      (lsq_full_o),
        .rs_load_o       (rs_load),
        .rob_load_o      (rob_load),
        .lsq_load_o      (lsq_load)
    );

    // stations take the head word and the tail tag
    res_station_bank i_rs (
        .clk          (clk),
        .rst_i        (rst_i),
        .load_i       (rs_load),
        .word_i       (head_word),
        .tag_i        (tail_tag),
        .exec_done_i  (exec_done_i),
        .exec_rs_i    (exec_rs_i),
        .alu_empty_o  (alu_empty),
        .ldst_empty_o (ldst_empty)
    );

    rob_alloc i_rob (
        .clk        (clk),
        .rst_i      (rst_i),
        .alloc_i    (rob_load),
        .retire_i   (retire_i),
        .tail_tag_o (tail_tag),
        .full_o     (rob_full_o)
    );

    ldst_queue i_lsq (
        .clk        (clk),
        .rst_i      (rst_i),
        .push_i     (lsq_load),
        .mem_done_i (mem_done_i),
        .full_o     (lsq_full_o)
    );

    // one-hot load vector to station index
    always_comb begin
        disp_rs = '0;
        for (int i = 0; i < NUM_RS; i++) begin
            if (rs_load[i]) begin
                disp_rs = rs_id_t'(i);
            end
        end
    end

    assign disp_rec.word = head_word;
    assign disp_rec.tag  = tail_tag;
    assign disp_rec.rs   = disp_rs;

    // valid for one cycle after the dispatch edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= rob_load;
        end
    end

    // record payload
    always_ff @(posedge clk) begin
        if (rob_load) begin
            issue_q <= disp_rec;
        end
    end

    assign issue_valid_o = issue_valid_q;
    assign issue_o       = issue_q;

endmodule

/* verilog/ldst_queue.sv */
`timescale 1ns/1ps

module ldst_queue (
    input  logic clk,
    input  logic rst_i,
    input  logic push_i,
    input  logic mem_done_i,
    output logic full_o
);
    import issue_cfg_pkg::*;

    // memory ops in flight
    lsq_cnt_t count_q;
    logic     do_push;
    logic     do_done;

    assign full_o  = (count_q == LSQ_DEPTH);

    // push only with room left
    assign do_push = push_i && !full_o;
    // done with nothing in flight is dropped
    assign do_done = mem_done_i && (count_q != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q <= '0;
        end else begin
            // push and done together cancel out
            case ({do_push, do_done})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* verilog/res_station_bank.sv */
`timescale 1ns/1ps

module res_station_bank (
    input  logic                               clk,
    input  logic                               rst_i,
    // one-hot capture from the controller
    input  issue_cfg_pkg::rs_sel_t             load_i,
    input  rv32i_issue_pkg::ctl_word_t         word_i,
    input  issue_cfg_pkg::rob_tag_t            tag_i,
    // completion from execute
    input  logic                               exec_done_i,
    input  issue_cfg_pkg::rs_id_t              exec_rs_i,
    // free flags
    output logic [issue_cfg_pkg::NUM_ALU_RS-1:0] alu_empty_o,
    output logic                               ldst_empty_o
);
    import rv32i_issue_pkg::*;
    import issue_cfg_pkg::*;

    // per-station state
    logic      busy_q [NUM_RS];
    ctl_word_t word_q [NUM_RS];
    rob_tag_t  tag_q  [NUM_RS];

    for (genvar i = 0; i < NUM_RS; i++) begin : g_station
        logic done_hit;

        // completion aimed at this station
        assign done_hit = exec_done_i && (exec_rs_i == rs_id_t'(i));

        always_ff @(posedge clk) begin
            if (rst_i) begin
                busy_q[i] <= 1'b0;
            end else if (load_i[i]) begin
                // controller only loads a free station
                busy_q[i] <= 1'b1;
            end else if (done_hit) begin
                // done on an idle station changes nothing
                busy_q[i] <= 1'b0;
            end
        end

        // payload captured with the load strobe
        always_ff @(posedge clk) begin
            if (load_i[i]) begin
                word_q[i] <= word_i;
                tag_q[i]  <= tag_i;
            end
        end
    end

    // alu free flags
    for (genvar j = 0; j < NUM_ALU_RS; j++) begin : g_alu_empty
        assign alu_empty_o[j] = !busy_q[j];
    end

    // memory station free flag
    assign ldst_empty_o = !busy_q[LDST_RS_ID];

endmodule

/* verilog/rob_alloc.sv */
`timescale 1ns/1ps

module rob_alloc (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    alloc_i,
    input  logic                    retire_i,
    output issue_cfg_pkg::rob_tag_t tail_tag_o,
    output logic                    full_o
);
    import issue_cfg_pkg::*;

    // oldest entry and next free entry
    rob_tag_t head_q;
    rob_tag_t tail_q;
    rob_cnt_t count_q;
    logic     do_alloc;
    logic     do_retire;

    assign full_o     = (count_q == ROB_DEPTH);
    // next dispatch gets the tail tag
    assign tail_tag_o = tail_q;

    // no allocation into a full buffer
    assign do_alloc  = alloc_i && !full_o;
    // retire of an empty buffer is dropped
    assign do_retire = retire_i && (count_q != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_alloc) begin
                tail_q <= (tail_q == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            // in-order retire from the head
            if (do_retire) begin
                head_q <= (head_q == rob_tag_t'(ROB_DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            case ({do_alloc, do_retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* verilog/rv32i_issue_pkg.sv */
package rv32i_issue_pkg;

    // instruction-side definitions shared by the issue stage

    // operation class from the decoder
    // only LD and ST are routed to the memory station
    typedef enum logic [2:0] {
        ALU = 3'd0,
        MUL = 3'd1,
        BR  = 3'd2,
        LD  = 3'd3,
        ST  = 3'd4
    } op_class_e;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // sign-extended immediate from decode
    typedef logic [31:0] imm_t;

    // function select for the execution unit
    typedef logic [3:0] funct_t;

    // decoded control word as delivered by the IR stage
    // op is the top field so the class is easy to spot in waves
    typedef struct packed {
        op_class_e op;
        // destination register
        reg_idx_t  dest_reg;
        // first source operand
        reg_idx_t  src1_reg;
        // second source operand
        reg_idx_t  src2_reg;
        // immediate operand
        imm_t      imm;
        // sub-operation
        funct_t    funct;
    } ctl_word_t;

endpackage
